/* rtl/videoPixel_config.svh */
// Sizing defines for the video pixel RTL, included by every file that needs a width or depth
`ifndef VIDEO_PIXEL_CONFIG_SVH
`define VIDEO_PIXEL_CONFIG_SVH

// --------------------------------------------------
// Display counters
// --------------------------------------------------

// Width of hPos, vPos and the programmed sizes
`define POS_WIDTH 11

// --------------------------------------------------
// Color depths
// --------------------------------------------------

// ARGB4444 layer pixel
`define COLOR_DEPTH 16

// RGB444 output pixel, alpha stripped
`define OUT_COLOR_DEPTH 12

// --------------------------------------------------
// Output buffering
// --------------------------------------------------

// Merge FIFO entries, two kept free for in-flight pixels
`define PIXEL_FIFO_DEPTH 16

`endif

/* rtl/VideoPixelPkg.sv */
// Pixel types shared by the layer drawers, the merge stage and the top, imported per module
`include "videoPixel_config.svh"

package VideoPixelPkg;

	// --------------------------------------------------
	// Color channel
	// --------------------------------------------------

	// One 4-bit channel, a quarter of the ARGB word
	typedef logic [`COLOR_DEPTH/4-1:0] colorCh;

	// Layer pixel
	// Alpha 0 is transparent, 15 fully opaque
	typedef struct packed {
		colorCh a;
		colorCh r;
		colorCh g;
		colorCh b;
	} argbPixel;

	// Display pixel after blending
	typedef struct packed {
		colorCh r;
		colorCh g;
		colorCh b;
	} rgbPixel;

endpackage

/* rtl/PixelDrawPosition.sv */
// Raster position generator walking the active area, stepped by the pipeline enable
`include "videoPixel_config.svh"

module PixelDrawPosition (
	input  logic                  iClk,
	input  logic                  arstN,
	input  logic                  iCke,
	input  logic [`POS_WIDTH-1:0] iLastH,
	input  logic [`POS_WIDTH-1:0] iLastV,
	output logic [`POS_WIDTH-1:0] oHpos,
	output logic [`POS_WIDTH-1:0] oVpos,
	output logic                  oAfe
);

	// End of line and end of frame
	logic hLast;
	logic vLast;

	assign hLast = (oHpos == iLastH);
	assign vLast = (oVpos == iLastV);

	// --------------------------------------------------
	// Position counters
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			oHpos <= '0;
			oVpos <= '0;
		end
		else if (iCke)
		begin
			if (hLast)
			begin
				// Wrap to next line
				oHpos <= '0;
				if (vLast)
					oVpos <= '0;
				else
					oVpos <= oVpos + 1'b1;
			end
			else
			begin
				oHpos <= oHpos + 1'b1;
			end
		end
	end

	// Frame end pulse
	// High on the cycle the last pixel is issued
	assign oAfe = iCke && hLast && vLast;

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------

	// Horizontal range against the latched width
	aHposInRange: assert property (@(posedge iClk) disable iff (!arstN)
		oHpos <= iLastH)
		else $error("hPos %0d beyond last column %0d", oHpos, iLastH);

endmodule

/* rtl/DotSquareGen.sv */
// Rectangle layer drawer, one per layer, emitting its color inside the box and clear outside
`include "videoPixel_config.svh"

module DotSquareGen (
	input  logic                   iClk,
	input  logic                   arstN,
	input  logic                   iCke,
	input  logic [`POS_WIDTH-1:0]  iHpos,
	input  logic [`POS_WIDTH-1:0]  iVpos,
	input  logic [`POS_WIDTH-1:0]  iDxs,
	input  logic [`POS_WIDTH-1:0]  iDxe,
	input  logic [`POS_WIDTH-1:0]  iDys,
	input  logic [`POS_WIDTH-1:0]  iDye,
	input  VideoPixelPkg::argbPixel iColor,
	output VideoPixelPkg::argbPixel oDd,
	output logic                   oVdd
);

	import VideoPixelPkg::*;

	// Fully clear pixel for uncovered positions
	localparam argbPixel TRANSPARENT = '0;

	// --------------------------------------------------
	// Coverage test
	// --------------------------------------------------

	// Start edges inclusive
	// End edges exclusive
	logic inX;
	logic inY;
	logic covered;

	assign inX     = (iHpos >= iDxs) && (iHpos < iDxe);
	assign inY     = (iVpos >= iDys) && (iVpos < iDye);
	assign covered = inX && inY;

	// Layer pixel before the output register
	argbPixel dotNext;

	assign dotNext = covered ? iColor : TRANSPARENT;

	// --------------------------------------------------
	// Output register
	// --------------------------------------------------

	// Pixel payload
	// Held while the pipeline is stalled
	always_ff @(posedge iClk)
	begin
		if (iCke)
			oDd <= dotNext;
	end

	// Valid strobe
	// One cycle behind each enabled position
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			oVdd <= 1'b0;
		else
			oVdd <= iCke;
	end

endmodule

/* rtl/PixelFifo.sv */
// Synchronous circular FIFO for merged output pixels, with early full for in-flight writes
`include "videoPixel_config.svh"

module PixelFifo #(
	parameter int pDepth = 16
) (
	input  logic                  iClk,
	input  logic                  arstN,
	input  logic                  iWe,
	input  logic                  iRe,
	input  VideoPixelPkg::rgbPixel iData,
	output VideoPixelPkg::rgbPixel oData,
	output logic                  oFull,
	output logic                  oEmp
);

	import VideoPixelPkg::*;

	localparam int PTR_W = $clog2(pDepth);
	localparam int CNT_W = $clog2(pDepth + 1);

	// Storage
	logic [`OUT_COLOR_DEPTH-1:0] mem [0:pDepth-1];

	logic [PTR_W-1:0] wrPtr;
	logic [PTR_W-1:0] rdPtr;
	logic [CNT_W-1:0] fillCnt;

	// --------------------------------------------------
	// Data path
	// --------------------------------------------------
	always_ff @(posedge iClk)
	begin
		if (iWe)
			mem[wrPtr] <= iData;
		// Read data registered on the read cycle
		if (iRe)
			oData <= rgbPixel'(mem[rdPtr]);
	end

	// --------------------------------------------------
	// Pointers and occupancy
	// --------------------------------------------------
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr   <= '0;
			rdPtr   <= '0;
			fillCnt <= '0;
		end
		else
		begin
			// Explicit wrap for non power of two depths
			if (iWe)
				wrPtr <= (wrPtr == PTR_W'(pDepth - 1)) ? '0 : wrPtr + 1'b1;
			if (iRe)
				rdPtr <= (rdPtr == PTR_W'(pDepth - 1)) ? '0 : rdPtr + 1'b1;
			case ({iWe, iRe})
				2'b10:   fillCnt <= fillCnt + 1'b1;
				2'b01:   fillCnt <= fillCnt - 1'b1;
				default: fillCnt <= fillCnt;
			endcase
		end
	end

	// Full with two slots still free
	assign oFull = (fillCnt >= CNT_W'(pDepth - 2));
	assign oEmp  = (fillCnt == '0);

	// Reader must honour empty
	aNoReadEmpty: assert property (@(posedge iClk) disable iff (!arstN)
		iRe |-> !oEmp)
		else $error("Pixel FIFO read while empty");

endmodule

/* rtl/DotMergeToPixel.sv */
// Two-layer alpha blend over a black backdrop, buffering RGB444 pixels for the display side
`include "videoPixel_config.svh"

module DotMergeToPixel (
	input  logic                   iClk,
	input  logic                   arstN,
	input  VideoPixelPkg::argbPixel iLower,
	input  VideoPixelPkg::argbPixel iUpper,
	input  logic                   iEds,
	input  logic                   iCke,
	output logic                   oFull,
	output VideoPixelPkg::rgbPixel  oPixel,
	output logic                   oVd
);

	import VideoPixelPkg::*;

	// Opaque black behind all layers
	localparam rgbPixel BACKDROP = '0;

	// One channel of upper over lower
	// Rounded divide by 15
	function automatic colorCh blendCh(
		input colorCh upper,
		input colorCh lower,
		input colorCh alpha
	);
		logic [8:0] acc;
		acc = upper * alpha + lower * (4'd15 - alpha) + 9'd7;
		blendCh = colorCh'(acc / 9'd15);
	endfunction

	// --------------------------------------------------
	// Blend, field first then player
	// --------------------------------------------------
	rgbPixel lowerMix;
	rgbPixel upperMix;

	// Field layer over black
	assign lowerMix.r = blendCh(iLower.r, BACKDROP.r, iLower.a);
	assign lowerMix.g = blendCh(iLower.g, BACKDROP.g, iLower.a);
	assign lowerMix.b = blendCh(iLower.b, BACKDROP.b, iLower.a);

	// Player layer over that
	assign upperMix.r = blendCh(iUpper.r, lowerMix.r, iUpper.a);
	assign upperMix.g = blendCh(iUpper.g, lowerMix.g, iUpper.a);
	assign upperMix.b = blendCh(iUpper.b, lowerMix.b, iUpper.a);

	// Blend register
	rgbPixel blendPix;
	logic    blendVd;

	always_ff @(posedge iClk)
	begin
		if (iEds)
			blendPix <= upperMix;
	end

	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			blendVd <= 1'b0;
		else
			blendVd <= iEds;
	end

	// --------------------------------------------------
	// Output FIFO
	// --------------------------------------------------
	logic fifoRe;
	logic fifoEmp;

	// Display side pulls whenever data is there
	assign fifoRe = iCke && !fifoEmp;

	PixelFifo #(
		.pDepth (`PIXEL_FIFO_DEPTH)
	) PIXEL_FIFO (
		.iClk   (iClk),
		.arstN  (arstN),
		.iWe    (blendVd),
		.iRe    (fifoRe),
		.iData  (blendPix),
		.oData  (oPixel),
		.oFull  (oFull),
		.oEmp   (fifoEmp)
	);

	// Valid lines up with registered FIFO data
	always_ff @(posedge iClk or negedge arstN)
	begin
		if (!arstN)
			oVd <= 1'b0;
		else
			oVd <= fifoRe;
	end

	// Early full must cover every pixel still in the pipe
	aNoOverflow: assert property (@(posedge iClk) disable iff (!arstN)
		blendVd |-> (PIXEL_FIFO.fillCnt < `PIXEL_FIFO_DEPTH) || fifoRe)
		else $error("Merged pixel written into a full FIFO");

endmodule

/* rtl/VideoPixelGen.sv */
// Top of the pixel generator chaining position, field and player layers and the merge FIFO
`include "videoPixel_config.svh"

module VideoPixelGen (
	input  logic                   iClk,
	input  logic                   arstN,
	input  logic                   iCke,
	input  logic [`POS_WIDTH-1:0]  iHdisplay,
	input  logic [`POS_WIDTH-1:0]  iVdisplay,
	input  logic [`POS_WIDTH-1:0]  iFieldDxs,
	input  logic [`POS_WIDTH-1:0]  iFieldDxe,
	input  logic [`POS_WIDTH-1:0]  iFieldDys,
	input  logic [`POS_WIDTH-1:0]  iFieldDye,
	input  VideoPixelPkg::argbPixel iFieldColor,
	input  logic [`POS_WIDTH-1:0]  iPlayerDxs,
	input  logic [`POS_WIDTH-1:0]  iPlayerDxe,
	input  logic [`POS_WIDTH-1:0]  iPlayerDys,
	input  logic [`POS_WIDTH-1:0]  iPlayerDye,
	input  VideoPixelPkg::argbPixel iPlayerColor,
	output VideoPixelPkg::rgbPixel  oPixel,
	output logic                   oVd
);

	import VideoPixelPkg::*;

	// --------------------------------------------------
	// Display size registers
	// --------------------------------------------------
	logic [`POS_WIDTH-1:0] lastH;
	logic [`POS_WIDTH-1:0] lastV;
	logic                  afe;

	// Last column and row as size minus one
	// Tracks the inputs in reset and latches again at each frame end
	always_ff @(posedge iClk)
	begin
		if (!arstN || afe)
		begin
			lastH <= iHdisplay - 1'b1;
			lastV <= iVdisplay - 1'b1;
		end
	end

	// --------------------------------------------------
	// Position generator
	// --------------------------------------------------
	logic                  full;
	logic                  drawCke;
	logic [`POS_WIDTH-1:0] hPos;
	logic [`POS_WIDTH-1:0] vPos;

	// Whole front end stalls on merge FIFO full
	assign drawCke = !full;

	PixelDrawPosition PIXEL_DRAW_POSITION (
		.iClk   (iClk),
		.arstN  (arstN),
		.iCke   (drawCke),
		.iLastH (lastH),
		.iLastV (lastV),
		.oHpos  (hPos),
		.oVpos  (vPos),
		.oAfe   (afe)
	);

	// --------------------------------------------------
	// Layers from lower to upper
	// --------------------------------------------------
	argbPixel fieldDd;
	argbPixel playerDd;
	logic     fieldVdd;
	logic     playerVdd;

	DotSquareGen FIELD_LAYER (
		.iClk (iClk),  .arstN (arstN), .iCke (drawCke),
		.iHpos (hPos), .iVpos (vPos),
		.iDxs (iFieldDxs), .iDxe (iFieldDxe), .iDys (iFieldDys), .iDye (iFieldDye),
		.iColor (iFieldColor), .oDd (fieldDd), .oVdd (fieldVdd)
	);

	DotSquareGen PLAYER_LAYER (
		.iClk (iClk),  .arstN (arstN), .iCke (drawCke),
		.iHpos (hPos), .iVpos (vPos),
		.iDxs (iPlayerDxs), .iDxe (iPlayerDxe), .iDys (iPlayerDys), .iDye (iPlayerDye),
		.iColor (iPlayerColor), .oDd (playerDd), .oVdd (playerVdd)
	);

	// --------------------------------------------------
	// Merge and output
	// --------------------------------------------------
	DotMergeToPixel DOT_MERGE_TO_PIXEL (
		.iClk   (iClk),
		.arstN  (arstN),
		.iLower (fieldDd),
		.iUpper (playerDd),
		.iEds   (fieldVdd && playerVdd),
		.iCke   (iCke),
		.oFull  (full),
		.oPixel (oPixel),
		.oVd    (oVd)
	);

endmodule

/* tests/VideoPixelGenTasks.svh */
// Directed tests and their helpers for inclusion inside the testbench module body
`ifndef VIDEO_PIXEL_GEN_TASKS_SVH
`define VIDEO_PIXEL_GEN_TASKS_SVH

	// Sizes, both rectangles and colors on one rising edge
	task automatic setScene(input int w, input int h,
		input int fxs, input int fxe, input int fys, input int fye, input argbPixel fc,
		input int pxs, input int pxe, input int pys, input int pye, input argbPixel pc);
		@(posedge iClk);
		iHdisplay    <= `POS_WIDTH'(w);
		iVdisplay    <= `POS_WIDTH'(h);
		iFieldDxs    <= `POS_WIDTH'(fxs);
		iFieldDxe    <= `POS_WIDTH'(fxe);
		iFieldDys    <= `POS_WIDTH'(fys);
		iFieldDye    <= `POS_WIDTH'(fye);
		iFieldColor  <= fc;
		iPlayerDxs   <= `POS_WIDTH'(pxs);
		iPlayerDxe   <= `POS_WIDTH'(pxe);
		iPlayerDys   <= `POS_WIDTH'(pys);
		iPlayerDye   <= `POS_WIDTH'(pye);
		iPlayerColor <= pc;
	endtask

	// Reset for 4 cycles while the sizes latch
	task automatic resetDut(input logic cke);
		@(posedge iClk);
		arstN <= 1'b0;
		iCke  <= cke;
		repeat (4) @(posedge iClk);
		arstN <= 1'b1;
	endtask

	// --------------------------------------------------
	// Pixel collection against the model
	// --------------------------------------------------
	task automatic collectPixels(input int nPix, input bit randCke, input bit checkFrame);
		int      cycles;
		int      got;
		int      hh;
		int      vv;
		int      marks[$];
		rgbPixel exp;
		cycles = 0;
		got    = 0;
		while (got < nPix && cycles < nPix * 20 + 100)
		begin
			@(posedge iClk);
			if (randCke)
				iCke <= 1'($random(seed));
			@(negedge iClk);
			cycles++;
			// Frame end marks counted in output pixels
			if (dut.afe === 1'b1)
				marks.push_back(got);
			if (oVd === 1'b1)
			begin
				hh  = got % iHdisplay;
				vv  = (got / iHdisplay) % iVdisplay;
				exp = modelPixel(hh, vv);
				assert (oPixel === exp)
				else
				begin
					errors++;
					$display("MISMATCH at %0t: oPixel #%0d (%0d,%0d) got %h expected %h",
						$time, got, hh, vv, oPixel, exp);
				end
				got++;
			end
		end
		if (got < nPix)
		begin
			errors++;
			$display("Timed out with %0d of %0d pixels received", got, nPix);
		end
		if (checkFrame && marks.size() < 2)
		begin
			errors++;
			$display("Fewer than two frame ends seen during collection");
		end
		// With steady flow the output count per frame equals the frame size
		for (int i = 1; checkFrame && i < marks.size(); i++)
			assert (marks[i] - marks[i-1] == iHdisplay * iVdisplay)
			else
			begin
				errors++;
				$display("MISMATCH at %0t: oVd count per frame got %0d expected %0d",
					$time, marks[i] - marks[i-1], iHdisplay * iVdisplay);
			end
	endtask

	// --------------------------------------------------
	// Directed tests
	// --------------------------------------------------
	task automatic blankFrameIsBlack();
		setScene(8, 4, 0, 0, 0, 0, '0, 0, 0, 0, 0, '0);
		resetDut(1'b1);
		collectPixels(64, 1'b0, 1'b1);
	endtask

	// Opaque box 2..4 by 1..2
	task automatic fieldRectBounds();
		setScene(8, 4, 2, 5, 1, 3, 16'hFA50, 0, 0, 0, 0, '0);
		resetDut(1'b1);
		collectPixels(32, 1'b0, 1'b0);
	endtask

	task automatic playerOverField();
		// Opaque player first
		setScene(8, 4, 1, 6, 0, 4, 16'hF804, 4, 8, 2, 4, 16'hF0F0);
		resetDut(1'b1);
		collectPixels(32, 1'b0, 1'b0);
		// Alpha 7 player with the overlap worked out by hand as 472
		setScene(8, 4, 1, 6, 0, 4, 16'hF804, 4, 8, 2, 4, 16'h70F0);
		resetDut(1'b1);
		@(posedge iClk);
		assert (modelPixel(4, 2) == 12'h472)
		else
		begin
			errors++;
			$display("Reference model disagrees with the hand blend at (4,2)");
		end
		collectPixels(32, 1'b0, 1'b0);
	endtask

	task automatic stallThenRandomRead();
		setScene(8, 4, 1, 5, 0, 3, 16'hF3C9, 3, 8, 1, 4, 16'h7E2A);
		resetDut(1'b0);
		// FIFO fills up and nothing may leave
		for (int i = 0; i < 80; i++)
		begin
			@(negedge iClk);
			assert (oVd !== 1'b1)
			else
			begin
				errors++;
				$display("Output valid at %0t while the display enable was low", $time);
			end
		end
		collectPixels(64, 1'b1, 1'b0);
	endtask

	// Marker box in the last column and row
	task automatic resizeAndWrap();
		setScene(5, 3, 4, 5, 2, 3, 16'hFFFF, 0, 1, 0, 1, 16'hF111);
		resetDut(1'b1);
		collectPixels(30, 1'b0, 1'b1);
	endtask

`endif

/* tests/VideoPixelGenTb.sv */
// Testbench top for the pixel generator that runs the directed tests from the included tasks
`include "videoPixel_config.svh"

module VideoPixelGenTb;

	import VideoPixelPkg::*;

	// Clock, reset and display side enable
	logic iClk = 1'b0;
	logic arstN;
	logic iCke;

	// Programmed sizes and layer rectangles
	logic [`POS_WIDTH-1:0] iHdisplay;
	logic [`POS_WIDTH-1:0] iVdisplay;
	logic [`POS_WIDTH-1:0] iFieldDxs;
	logic [`POS_WIDTH-1:0] iFieldDxe;
	logic [`POS_WIDTH-1:0] iFieldDys;
	logic [`POS_WIDTH-1:0] iFieldDye;
	logic [`POS_WIDTH-1:0] iPlayerDxs;
	logic [`POS_WIDTH-1:0] iPlayerDxe;
	logic [`POS_WIDTH-1:0] iPlayerDys;
	logic [`POS_WIDTH-1:0] iPlayerDye;
	argbPixel              iFieldColor;
	argbPixel              iPlayerColor;

	// DUT outputs
	rgbPixel oPixel;
	logic    oVd;

	int     errors;
	integer seed;

	// 10 unit clock period
	always
	begin
		#5 iClk = !iClk;
	end

	VideoPixelGen dut (
		.iClk         (iClk),
		.arstN        (arstN),
		.iCke         (iCke),
		.iHdisplay    (iHdisplay),
		.iVdisplay    (iVdisplay),
		.iFieldDxs    (iFieldDxs),
		.iFieldDxe    (iFieldDxe),
		.iFieldDys    (iFieldDys),
		.iFieldDye    (iFieldDye),
		.iFieldColor  (iFieldColor),
		.iPlayerDxs   (iPlayerDxs),
		.iPlayerDxe   (iPlayerDxe),
		.iPlayerDys   (iPlayerDys),
		.iPlayerDye   (iPlayerDye),
		.iPlayerColor (iPlayerColor),
		.oPixel       (oPixel),
		.oVd          (oVd)
	);

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// Upper over lower with rounding by the upper alpha
	function automatic int blendChannel(input int upper, input int lower, input int alpha);
		return (upper * alpha + lower * (15 - alpha) + 7) / 15;
	endfunction

	// End edges exclusive
	function automatic bit covers(input int h, input int v, input int xs, input int xe,
		input int ys, input int ye);
		return (h >= xs) && (h < xe) && (v >= ys) && (v < ye);
	endfunction

	// Expected display pixel at one raster position
	function automatic rgbPixel modelPixel(input int h, input int v);
		argbPixel fld;
		argbPixel ply;
		rgbPixel  mix;
		fld = covers(h, v, iFieldDxs, iFieldDxe, iFieldDys, iFieldDye) ? iFieldColor : '0;
		ply = covers(h, v, iPlayerDxs, iPlayerDxe, iPlayerDys, iPlayerDye) ? iPlayerColor : '0;
		// Field over black and then player over that
		mix.r = 4'(blendChannel(ply.r, blendChannel(fld.r, 0, fld.a), ply.a));
		mix.g = 4'(blendChannel(ply.g, blendChannel(fld.g, 0, fld.a), ply.a));
		mix.b = 4'(blendChannel(ply.b, blendChannel(fld.b, 0, fld.a), ply.a));
		return mix;
	endfunction

	`include "VideoPixelGenTasks.svh"

	// --------------------------------------------------
	// Test sequence
	// --------------------------------------------------
	initial
	begin
		seed         = 98;
		errors       = 0;
		arstN        <= 1'b0;
		iCke         <= 1'b1;
		iHdisplay    <= `POS_WIDTH'(8);
		iVdisplay    <= `POS_WIDTH'(4);
		iFieldDxs    <= '0;
		iFieldDxe    <= '0;
		iFieldDys    <= '0;
		iFieldDye    <= '0;
		iFieldColor  <= '0;
		iPlayerDxs   <= '0;
		iPlayerDxe   <= '0;
		iPlayerDys   <= '0;
		iPlayerDye   <= '0;
		iPlayerColor <= '0;
		repeat (4) @(posedge iClk);
		arstN <= 1'b1;

		blankFrameIsBlack();
		fieldRectBounds();
		playerOverField();
		stallThenRandomRead();
		resizeAndWrap();

		$display("Closing count: %0d errors", errors);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+rtl
+incdir+tests
rtl/VideoPixelPkg.sv
rtl/PixelDrawPosition.sv
rtl/DotSquareGen.sv
rtl/PixelFifo.sv
rtl/DotMergeToPixel.sv
rtl/VideoPixelGen.sv
tests/VideoPixelGenTb.sv
